// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= game_audio_tb
RTL_TOP   ?= game_audio_top
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
RUN_ARGS  ?= +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/game_audio_assert.sv ====
`timescale 1ns/100ps

`include "game_audio_macros.svh"

module game_audio_assert (
	input logic                        clk,
	input logic                        resetN,
	input logic                        start_of_frame,
	input logic                        music_on,
	input game_audio_pkg::game_event_t events,
	input game_audio_pkg::tone_req_t   sfx_tone,
	input game_audio_pkg::tone_req_t   music_tone,
	input game_audio_pkg::tone_req_t   tone,
	input game_audio_pkg::audio_src_t  source,
	input logic                        audio_out
);

	int                       fail_cnt = 0;
	logic                     track;
	int                       seen;
	int                       hold_len;
	logic [`AUDIO_FREQ_W-1:0] first_freq;
	logic [2:0]               mel_idx;
	logic [`AUDIO_FREQ_W-1:0] last_mfreq;
	logic                     last_men;
	logic [`AUDIO_FREQ_W-1:0] last_freq;
	logic                     last_out;
	int                       run;
	logic                     armed;

	// First note of an effect, highest priority strobe wins
	function automatic logic [`AUDIO_FREQ_W-1:0] first_note(
		input game_audio_pkg::game_event_t ev
	);
		if (ev.player_hit)
			return `NOTE_MI;
		if (ev.pickup)
			return `NOTE_SOL;
		if (ev.bird_hit)
			return `NOTE_FA_D;
		if (ev.level_up)
			return `NOTE_SILENCE;
		return `NOTE_SOL;
	endfunction

	function automatic logic [`AUDIO_FREQ_W-1:0] tune_note(input logic [2:0] idx);
		logic [`AUDIO_FREQ_W-1:0] tune [8];
		tune = '{`NOTE_DO, `NOTE_MI, `NOTE_SOL, `NOTE_MI,
			`NOTE_LA, `NOTE_SOL, `NOTE_FA_D, `NOTE_SILENCE};
		return tune[idx];
	endfunction

	// ----------------------------------------------------------------------
	// Trackers
	// ----------------------------------------------------------------------

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			track      <= 1'b0;
			seen       <= 0;
			hold_len   <= 0;
			first_freq <= '0;
			mel_idx    <= '0;
			last_mfreq <= '0;
			last_men   <= 1'b0;
			last_freq  <= '0;
			last_out   <= 1'b0;
			run        <= 0;
			armed      <= 1'b0;
		end else begin
			if (!sfx_tone.en && events != '0) begin
				track      <= 1'b1;
				seen       <= 0;
				hold_len   <= (!events.player_hit && events.pickup) ? `DUR_LONG : `DUR_NORMAL;
				first_freq <= first_note(events);
			end else if (track) begin
				if (seen == hold_len)
					track <= 1'b0;
				else if (start_of_frame)
					seen <= seen + 1;
			end
			last_mfreq <= music_tone.freq;
			last_men   <= music_tone.en;
			if (!music_tone.en)
				mel_idx <= '0;
			else if (last_men && music_tone.freq != last_mfreq)
				mel_idx <= mel_idx + 3'd1;
			// Half period length since the last toggle
			last_freq <= tone.freq;
			last_out  <= audio_out;
			if (tone.freq != last_freq) begin
				armed <= 1'b0;
				run   <= 1;
			end else if (audio_out != last_out) begin
				armed <= 1'b1;
				run   <= 1;
			end else begin
				run <= run + 1;
			end
		end
	end

	// ----------------------------------------------------------------------
	// Output rules
	// ----------------------------------------------------------------------

	reset_quiet: assert property (@(posedge clk)
		!resetN || $rose(resetN) |-> !tone.en && source == game_audio_pkg::SRC_NONE && !audio_out)
		else begin fail_cnt++; $error("outputs not quiet around reset"); end

	sfx_wins: assert property (@(posedge clk) disable iff (!resetN)
		sfx_tone.en |-> source == game_audio_pkg::SRC_SFX && tone == sfx_tone)
		else begin fail_cnt++; $error("effect not selected"); end

	music_next: assert property (@(posedge clk) disable iff (!resetN)
		!sfx_tone.en && music_tone.en |-> source == game_audio_pkg::SRC_MUSIC && tone == music_tone)
		else begin fail_cnt++; $error("music not selected"); end

	none_quiet: assert property (@(posedge clk) disable iff (!resetN)
		!sfx_tone.en && !music_tone.en |-> !tone.en && source == game_audio_pkg::SRC_NONE)
		else begin fail_cnt++; $error("tone enabled with no source"); end

	first_hold: assert property (@(posedge clk) disable iff (!resetN)
		track && seen <= hold_len |-> tone.en && tone.freq == first_freq)
		else begin fail_cnt++; $error("first effect note wrong or too short"); end

	tune_start: assert property (@(posedge clk) disable iff (!resetN)
		music_tone.en && !last_men |-> music_tone.freq == `NOTE_DO)
		else begin fail_cnt++; $error("tune did not start on first note"); end

	tune_order: assert property (@(posedge clk) disable iff (!resetN)
		music_tone.en && last_men && music_tone.freq != last_mfreq
			|-> music_tone.freq == tune_note(mel_idx + 3'd1))
		else begin fail_cnt++; $error("tune note out of order"); end

	music_stop: assert property (@(posedge clk) disable iff (!resetN)
		$fell(music_on) |=> !music_tone.en)
		else begin fail_cnt++; $error("music still enabled after music_on fell"); end

	half_period: assert property (@(posedge clk) disable iff (!resetN)
		armed && audio_out != last_out && tone.freq == last_freq && tone.freq != '0
			|-> run == int'(tone.freq) + 1)
		else begin fail_cnt++; $error("square wave half period wrong"); end

	silent_low: assert property (@(posedge clk) disable iff (!resetN)
		tone.freq == '0 |=> !audio_out)
		else begin fail_cnt++; $error("audio_out high during silence"); end

endmodule

// ==== dv/game_audio_tb.sv ====
`timescale 1ns/100ps

`include "game_audio_macros.svh"

module game_audio_tb;

	// Longest effect with margin, about 30 sequences in the run
	localparam int SEQ_CYCLES = 400;
	localparam int MAX_CYCLES = SEQ_CYCLES * 50;

	logic                        clk;
	logic                        resetN;
	logic                        start_of_frame;
	logic                        music_on;
	game_audio_pkg::game_event_t events;
	game_audio_pkg::tone_req_t   tone;
	game_audio_pkg::audio_src_t  source;
	logic                        audio_out;
	int                          seed;
	int                          errors;
	int                          cycles;
	int                          frames;

	game_audio_top dut_i (
		.clk            (clk),
		.resetN         (resetN),
		.start_of_frame (start_of_frame),
		.events         (events),
		.music_on       (music_on),
		.tone           (tone),
		.source         (source),
		.audio_out      (audio_out)
	);

	bind game_audio_top game_audio_assert assert_i (
		.clk            (clk),
		.resetN         (resetN),
		.start_of_frame (start_of_frame),
		.music_on       (music_on),
		.events         (events),
		.sfx_tone       (sfx_tone),
		.music_tone     (music_tone),
		.tone           (tone),
		.source         (source),
		.audio_out      (audio_out)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	// Cycle and frame counts, plus the run limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (start_of_frame)
			frames <= frames + 1;
		if (cycles == MAX_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
			show_counts();
			$display("STATUS: FAIL");
			$finish;
		end
	end

	// One frame pulse every 16 cycles
	always @(negedge clk) begin
		start_of_frame <= (cycles % 16 == 15);
	end

	task automatic show_counts();
		$display("Errors: %0d value checks, %0d assertion failures",
			errors, dut_i.assert_i.fail_cnt);
	endtask

	task automatic wait_sfx_done();
		@(negedge clk);
		while (source == game_audio_pkg::SRC_SFX)
			@(negedge clk);
	endtask

	task automatic pulse_event(input game_audio_pkg::game_event_t ev);
		events = ev;
		@(negedge clk);
		events = '0;
	endtask

	// Strobe every cycle so each note end restarts the same note
	task automatic hold_effect(input game_audio_pkg::game_event_t ev, input int n);
		repeat (n)
			pulse_event(ev);
	endtask

	// Play one effect with music off and measure its length in frames
	task automatic run_effect(input game_audio_pkg::game_event_t ev, input int exp_frames);
		int f0;
		wait_sfx_done();
		pulse_event(ev);
		f0 = frames;
		wait_sfx_done();
		if (frames - f0 != exp_frames) begin
			errors++;
			$display("[ERROR] %0t frames: expected %0d, actual %0d",
				$time, exp_frames, frames - f0);
		end
		if (tone.en !== 1'b0) begin
			errors++;
			$display("[ERROR] %0t tone.en: expected 0, actual %b", $time, tone.en);
		end
	endtask

	initial begin
		seed           = 32'ha630_db70;
		errors         = 0;
		cycles         = 0;
		frames         = 0;
		resetN         = 1'b0;
		start_of_frame = 1'b0;
		music_on       = 1'b0;
		events         = '0;
		repeat (16) @(negedge clk);
		resetN = 1'b1;
		repeat (4) @(negedge clk);

		// Single effects: hit, pickup, bird hit, level up, shot
		run_effect(5'b10000, 12);
		run_effect(5'b01000, 24);
		run_effect(5'b00100, 12);
		run_effect(5'b00010, 12);
		run_effect(5'b00001, 7);
		// Simultaneous strobes
		run_effect(5'b10001, 12);
		run_effect(5'b01100, 24);
		run_effect(5'b00011, 12);

		// Long pickup note for several half periods, then straight into silence
		wait_sfx_done();
		hold_effect(5'b01000, 1500);
		hold_effect(5'b00010, 200);
		wait_sfx_done();

		// Tune alone for more than one loop
		music_on = 1'b1;
		repeat (40 * 16) @(negedge clk);

		// Random effects over the music
		repeat (3000) begin
			@(negedge clk);
			if ($random(seed) % 64 == 0)
				pulse_event(game_audio_pkg::game_event_t'($random(seed)));
		end
		wait_sfx_done();
		music_on = 1'b0;
		repeat (8) @(negedge clk);

		show_counts();
		if (errors == 0 && dut_i.assert_i.fail_cnt == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// ==== hw/game_audio_macros.svh ====
`ifndef GAME_AUDIO_MACROS_SVH
`define GAME_AUDIO_MACROS_SVH

// ----------------------------------------------------------------------
// Note codes
// ----------------------------------------------------------------------

// Half period of a note in clock cycles
`define AUDIO_FREQ_W 10

`define NOTE_DO     10'h2EA
`define NOTE_MI     10'h250
`define NOTE_FA_D   10'h20F
`define NOTE_SOL    10'h1F2
`define NOTE_SOL_D  10'h1D6
`define NOTE_LA     10'h1BB
`define NOTE_SI     10'h18B

// No tone, divider held off
`define NOTE_SILENCE 10'h000

// ----------------------------------------------------------------------
// Note lengths, counted in frames
// ----------------------------------------------------------------------

`define DUR_W 4

`define DUR_LONG    4'd8
`define DUR_NORMAL  4'd4
`define DUR_SHORT   4'd2
`define DUR_TINY    4'd1

`endif

// ==== hw/game_audio_pkg.sv ====
`include "game_audio_macros.svh"

package game_audio_pkg;

	// One-cycle strobes from the game logic
	typedef struct packed {
		logic player_hit;
		logic pickup;
		logic bird_hit;
		logic level_up;
		logic shot_deploy;
	} game_event_t;

	// Note request, freq of zero means silence
	typedef struct packed {
		logic [`AUDIO_FREQ_W-1:0] freq;
		logic                     en;
	} tone_req_t;

	// Effect sequencer states, three steps per effect
	typedef enum logic [4:0] {
		ST_IDLE,
		ST_HIT_1, ST_HIT_2, ST_HIT_3,
		ST_PICKUP_1, ST_PICKUP_2, ST_PICKUP_3,
		ST_BIRD_1, ST_BIRD_2, ST_BIRD_3,
		ST_LVL_1, ST_LVL_2, ST_LVL_3,
		ST_SHOT_1, ST_SHOT_2, ST_SHOT_3
	} sfx_state_t;

	// Which player owns the output
	typedef enum logic [1:0] {
		SRC_NONE,
		SRC_SFX,
		SRC_MUSIC
	} audio_src_t;

endpackage

// ==== hw/game_audio_top.sv ====
`timescale 1ns/100ps

module game_audio_top (
	input  logic                        clk,
	input  logic                        resetN,
	input  logic                        start_of_frame,
	input  game_audio_pkg::game_event_t events,
	input  logic                        music_on,
	output game_audio_pkg::tone_req_t   tone,
	output game_audio_pkg::audio_src_t  source,
	output logic                        audio_out
);

	game_audio_pkg::tone_req_t sfx_tone;
	game_audio_pkg::tone_req_t music_tone;

	sfx_sequencer sfx_i (
		.clk            (clk),
		.resetN         (resetN),
		.start_of_frame (start_of_frame),
		.events         (events),
		.sfx_tone       (sfx_tone)
	);

	melody_player melody_i (
		.clk            (clk),
		.resetN         (resetN),
		.start_of_frame (start_of_frame),
		.music_on       (music_on),
		.music_tone     (music_tone)
	);

	tone_output_stage out_i (
		.clk        (clk),
		.resetN     (resetN),
		.sfx_tone   (sfx_tone),
		.music_tone (music_tone),
		.tone       (tone),
		.source     (source),
		.audio_out  (audio_out)
	);

endmodule

// ==== hw/melody_player.sv ====
`timescale 1ns/100ps

`include "game_audio_macros.svh"

module melody_player (
	input  logic                      clk,
	input  logic                      resetN,
	input  logic                      start_of_frame,
	input  logic                      music_on,
	output game_audio_pkg::tone_req_t music_tone
);

	logic [2:0]        note_idx;
	logic [2:0]        note_idx_nxt;
	logic [`DUR_W-1:0] frame_cnt;
	logic [`DUR_W-1:0] frame_cnt_nxt;

	// ----------------------------------------------------------------------
	// Background tune
	// ----------------------------------------------------------------------

	function automatic logic [`AUDIO_FREQ_W-1:0] melody_note(input logic [2:0] idx);
		case (idx)
			3'd0:    melody_note = `NOTE_DO;
			3'd1:    melody_note = `NOTE_MI;
			3'd2:    melody_note = `NOTE_SOL;
			3'd3:    melody_note = `NOTE_MI;
			3'd4:    melody_note = `NOTE_LA;
			3'd5:    melody_note = `NOTE_SOL;
			3'd6:    melody_note = `NOTE_FA_D;
			// Rest before the tune repeats
			default: melody_note = `NOTE_SILENCE;
		endcase
	endfunction

	// Step every NORMAL frames, index wraps by itself
	always_comb begin
		note_idx_nxt  = note_idx;
		frame_cnt_nxt = frame_cnt;
		if (!music_on) begin
			note_idx_nxt  = 3'd0;
			frame_cnt_nxt = '0;
		end else if (start_of_frame) begin
			if (frame_cnt == `DUR_NORMAL - 4'd1) begin
				frame_cnt_nxt = '0;
				note_idx_nxt  = note_idx + 3'd1;
			end else begin
				frame_cnt_nxt = frame_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			note_idx        <= 3'd0;
			frame_cnt       <= '0;
			music_tone.freq <= `NOTE_SILENCE;
			music_tone.en   <= 1'b0;
		end else begin
			note_idx        <= note_idx_nxt;
			frame_cnt       <= frame_cnt_nxt;
			music_tone.freq <= music_on ? melody_note(note_idx_nxt) : `NOTE_SILENCE;
			music_tone.en   <= music_on;
		end
	end

endmodule

// ==== hw/sfx_sequencer.sv ====
`timescale 1ns/100ps

`include "game_audio_macros.svh"

module sfx_sequencer (
	input  logic                     clk,
	input  logic                     resetN,
	input  logic                     start_of_frame,
	input  game_audio_pkg::game_event_t events,
	output game_audio_pkg::tone_req_t   sfx_tone
);

	game_audio_pkg::sfx_state_t state;
	game_audio_pkg::sfx_state_t next_state;
	logic [`DUR_W-1:0]          frame_cnt;

	// ----------------------------------------------------------------------
	// Note table
	// ----------------------------------------------------------------------

	function automatic logic [`AUDIO_FREQ_W-1:0] step_note(
		input game_audio_pkg::sfx_state_t st
	);
		case (st)
			game_audio_pkg::ST_HIT_1:    step_note = `NOTE_MI;
			game_audio_pkg::ST_HIT_2:    step_note = `NOTE_DO;
			game_audio_pkg::ST_PICKUP_1: step_note = `NOTE_SOL;
			game_audio_pkg::ST_PICKUP_2: step_note = `NOTE_MI;
			game_audio_pkg::ST_PICKUP_3: step_note = `NOTE_LA;
			game_audio_pkg::ST_BIRD_1:   step_note = `NOTE_FA_D;
			game_audio_pkg::ST_BIRD_2:   step_note = `NOTE_SOL_D;
			game_audio_pkg::ST_BIRD_3:   step_note = `NOTE_SI;
			game_audio_pkg::ST_SHOT_1:   step_note = `NOTE_SOL;
			game_audio_pkg::ST_SHOT_2:   step_note = `NOTE_MI;
			game_audio_pkg::ST_SHOT_3:   step_note = `NOTE_DO;
			// Idle, last hit step and all level-up steps
			default:                     step_note = `NOTE_SILENCE;
		endcase
	endfunction

	function automatic logic [`DUR_W-1:0] step_len(
		input game_audio_pkg::sfx_state_t st
	);
		case (st)
			game_audio_pkg::ST_IDLE:     step_len = '0;
			game_audio_pkg::ST_PICKUP_1,
			game_audio_pkg::ST_PICKUP_2,
			game_audio_pkg::ST_PICKUP_3: step_len = `DUR_LONG;
			game_audio_pkg::ST_SHOT_2:   step_len = `DUR_SHORT;
			game_audio_pkg::ST_SHOT_3:   step_len = `DUR_TINY;
			default:                     step_len = `DUR_NORMAL;
		endcase
	endfunction

	// ----------------------------------------------------------------------
	// Next step
	// ----------------------------------------------------------------------

	// A new event restarts from its first step, highest priority first
	always_comb begin
		next_state = game_audio_pkg::ST_IDLE;
		if (events.player_hit) begin
			next_state = game_audio_pkg::ST_HIT_1;
		end else if (events.pickup) begin
			next_state = game_audio_pkg::ST_PICKUP_1;
		end else if (events.bird_hit) begin
			next_state = game_audio_pkg::ST_BIRD_1;
		end else if (events.level_up) begin
			next_state = game_audio_pkg::ST_LVL_1;
		end else if (events.shot_deploy) begin
			next_state = game_audio_pkg::ST_SHOT_1;
		end else begin
			case (state)
				game_audio_pkg::ST_HIT_1:    next_state = game_audio_pkg::ST_HIT_2;
				game_audio_pkg::ST_HIT_2:    next_state = game_audio_pkg::ST_HIT_3;
				game_audio_pkg::ST_PICKUP_1: next_state = game_audio_pkg::ST_PICKUP_2;
				game_audio_pkg::ST_PICKUP_2: next_state = game_audio_pkg::ST_PICKUP_3;
				game_audio_pkg::ST_BIRD_1:   next_state = game_audio_pkg::ST_BIRD_2;
				game_audio_pkg::ST_BIRD_2:   next_state = game_audio_pkg::ST_BIRD_3;
				game_audio_pkg::ST_LVL_1:    next_state = game_audio_pkg::ST_LVL_2;
				game_audio_pkg::ST_LVL_2:    next_state = game_audio_pkg::ST_LVL_3;
				game_audio_pkg::ST_SHOT_1:   next_state = game_audio_pkg::ST_SHOT_2;
				game_audio_pkg::ST_SHOT_2:   next_state = game_audio_pkg::ST_SHOT_3;
				// Third steps and idle fall back to idle
				default:                     next_state = game_audio_pkg::ST_IDLE;
			endcase
		end
	end

	// ----------------------------------------------------------------------
	// State, frame counter and tone registers
	// ----------------------------------------------------------------------

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			state         <= game_audio_pkg::ST_IDLE;
			frame_cnt     <= '0;
			sfx_tone.freq <= `NOTE_SILENCE;
			sfx_tone.en   <= 1'b0;
		end else if (frame_cnt == '0) begin
			// Note finished, events only get in here
			state         <= next_state;
			frame_cnt     <= step_len(next_state);
			sfx_tone.freq <= step_note(next_state);
			// Silent steps still hold the music off
			sfx_tone.en   <= (next_state != game_audio_pkg::ST_IDLE);
		end else if (start_of_frame) begin
			frame_cnt <= frame_cnt - 1'b1;
		end
	end

endmodule

// ==== hw/tone_output_stage.sv ====
`timescale 1ns/100ps

`include "game_audio_macros.svh"

module tone_output_stage (
	input  logic                       clk,
	input  logic                       resetN,
	input  game_audio_pkg::tone_req_t  sfx_tone,
	input  game_audio_pkg::tone_req_t  music_tone,
	output game_audio_pkg::tone_req_t  tone,
	output game_audio_pkg::audio_src_t source,
	output logic                       audio_out
);

	logic [`AUDIO_FREQ_W-1:0] prev_freq;
	logic [`AUDIO_FREQ_W-1:0] half_cnt;

	// ----------------------------------------------------------------------
	// Source select
	// ----------------------------------------------------------------------

	// Effects win over the music
	always_comb begin
		if (sfx_tone.en) begin
			tone   = sfx_tone;
			source = game_audio_pkg::SRC_SFX;
		end else if (music_tone.en) begin
			tone   = music_tone;
			source = game_audio_pkg::SRC_MUSIC;
		end else begin
			tone.freq = `NOTE_SILENCE;
			tone.en   = 1'b0;
			source    = game_audio_pkg::SRC_NONE;
		end
	end

	// ----------------------------------------------------------------------
	// Square wave divider
	// ----------------------------------------------------------------------

	// Half period is freq + 1 cycles
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			prev_freq <= `NOTE_SILENCE;
			half_cnt  <= '0;
			audio_out <= 1'b0;
		end else begin
			prev_freq <= tone.freq;
			if (tone.freq != prev_freq || tone.freq == `NOTE_SILENCE) begin
				// New note starts low with a fresh count
				half_cnt  <= '0;
				audio_out <= 1'b0;
			end else if (half_cnt == tone.freq) begin
				half_cnt  <= '0;
				audio_out <= ~audio_out;
			end else begin
				half_cnt <= half_cnt + 1'b1;
			end
		end
	end

endmodule

// ==== tb.f ====
+incdir+hw
hw/game_audio_pkg.sv
hw/sfx_sequencer.sv
hw/melody_player.sv
hw/tone_output_stage.sv
hw/game_audio_top.sv
dv/game_audio_assert.sv
dv/game_audio_tb.sv
